/* Bender.yml */
package:
  name: cpu16_backend

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/cpu16_isa_pkg.sv
      - hdl/cpu16_pipe_pkg.sv
      - hdl/exec_alu.sv
      - hdl/ex_mem_reg.sv
      - hdl/mem_stage.sv
      - hdl/mem_wb_reg.sv
      - hdl/cpu16_backend.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tb/tb_backend.sv

/* hdl/cpu16_backend.sv */
`include "cpu16_defines.svh"

module cpu16_backend (
  input  logic                        clk,
  input  logic                        reset,
  input  cpu16_isa_pkg::alu_op_e      alu_op,
  input  logic [`CPU16_DW-1:0]        rdata1,
  input  logic [`CPU16_DW-1:0]        rdata2,
  input  logic [`CPU16_DW-1:0]        extended,
  input  logic                        use_imm,
  input  logic [`CPU16_DW-1:0]        pc_added,
  input  logic [`CPU16_RW-1:0]        rf_waddr,
  input  logic                        rf_wen,
  input  logic                        dmem_wen,
  input  logic                        mem2reg,
  input  logic                        branch,
  input  cpu16_isa_pkg::branch_cond_e branch_cond,
  input  logic                        jal,
  output logic                        rf_wen_wb,
  output logic [`CPU16_RW-1:0]        rf_waddr_wb,
  output logic [`CPU16_DW-1:0]        wb_data,
  output logic                        branch_taken,
  output logic [`CPU16_DW-1:0]        redirect_target
);

  // execute stage.
  logic [`CPU16_DW-1:0] aluout;
  logic [`CPU16_FW-1:0] flag;
  logic [`CPU16_DW-1:0] branch_target;

  // ex/mem stage.
  logic [`CPU16_DW-1:0]        aluout_exmem;
  logic [`CPU16_FW-1:0]        flag_exmem;
  logic [`CPU16_DW-1:0]        rdata2_exmem;
  logic [`CPU16_DW-1:0]        branch_target_exmem;
  logic [`CPU16_DW-1:0]        pc_added_exmem;
  logic [`CPU16_RW-1:0]        rf_waddr_exmem;
  logic                        rf_wen_exmem;
  logic                        dmem_wen_exmem;
  logic                        mem2reg_exmem;
  logic                        branch_exmem;
  cpu16_isa_pkg::branch_cond_e branch_cond_exmem;
  logic                        jal_exmem;
  logic [`CPU16_DW-1:0]        mem_rdata;

  exec_alu u_exec_alu (
    .alu_op        (alu_op),
    .rdata1        (rdata1),
    .rdata2        (rdata2),
    .extended      (extended),
    .pc_added      (pc_added),
    .use_imm       (use_imm),
    .aluout        (aluout),
    .flag          (flag),
    .branch_target (branch_target)
  );

  ex_mem_reg u_ex_mem_reg (
    .clk                 (clk),
    .reset               (reset),
    .squash              (branch_taken), // kills the op behind a taken branch.
    .aluout              (aluout),
    .flag                (flag),
    .rdata2              (rdata2),
    .branch_target       (branch_target),
    .pc_added            (pc_added),
    .rf_waddr            (rf_waddr),
    .rf_wen              (rf_wen),
    .dmem_wen            (dmem_wen),
    .mem2reg             (mem2reg),
    .branch              (branch),
    .branch_cond         (branch_cond),
    .jal                 (jal),
    .aluout_exmem        (aluout_exmem),
    .flag_exmem          (flag_exmem),
    .rdata2_exmem        (rdata2_exmem),
    .branch_target_exmem (branch_target_exmem),
    .pc_added_exmem      (pc_added_exmem),
    .rf_waddr_exmem      (rf_waddr_exmem),
    .rf_wen_exmem        (rf_wen_exmem),
    .dmem_wen_exmem      (dmem_wen_exmem),
    .mem2reg_exmem       (mem2reg_exmem),
    .branch_exmem        (branch_exmem),
    .branch_cond_exmem   (branch_cond_exmem),
    .jal_exmem           (jal_exmem)
  );

  mem_stage u_mem_stage (
    .clk                 (clk),
    .aluout_exmem        (aluout_exmem),
    .rdata2_exmem        (rdata2_exmem),
    .branch_target_exmem (branch_target_exmem),
    .flag_exmem          (flag_exmem),
    .dmem_wen_exmem      (dmem_wen_exmem),
    .branch_exmem        (branch_exmem),
    .jal_exmem           (jal_exmem),
    .branch_cond_exmem   (branch_cond_exmem),
    .mem_rdata           (mem_rdata),
    .branch_taken        (branch_taken),
    .redirect_target     (redirect_target)
  );

  mem_wb_reg u_mem_wb_reg (
    .clk            (clk),
    .reset          (reset),
    .aluout_exmem   (aluout_exmem),
    .mem_rdata      (mem_rdata),
    .pc_added_exmem (pc_added_exmem),
    .rf_waddr_exmem (rf_waddr_exmem),
    .rf_wen_exmem   (rf_wen_exmem),
    .mem2reg_exmem  (mem2reg_exmem),
    .jal_exmem      (jal_exmem),
    .rf_wen_wb      (rf_wen_wb),
    .rf_waddr_wb    (rf_waddr_wb),
    .wb_data        (wb_data)
  );

endmodule

/* hdl/cpu16_defines.svh */
`ifndef CPU16_DEFINES_SVH
`define CPU16_DEFINES_SVH

// ==========================================================================
// datapath widths.
// ==========================================================================
`define CPU16_DW 16 // data, address and pc.
`define CPU16_RW 4  // register file address.
`define CPU16_FW 3  // alu flags.

// flag bit positions.
`define CPU16_FLAG_Z 0
`define CPU16_FLAG_C 1
`define CPU16_FLAG_N 2

// ==========================================================================
// data memory.
// ==========================================================================
`define CPU16_DMEM_WORDS 256 // word addressed, low address bits only.

`endif

/* hdl/cpu16_isa_pkg.sv */
package cpu16_isa_pkg;

  // alu operations. shifts act on operand a by one bit.
  typedef enum logic [2:0] {
    ALU_ADD   = 3'd0,
    ALU_SUB   = 3'd1,
    ALU_AND   = 3'd2,
    ALU_OR    = 3'd3,
    ALU_XOR   = 3'd4,
    ALU_SHL   = 3'd5,
    ALU_SHR   = 3'd6,
    ALU_PASSB = 3'd7
  } alu_op_e;

  // branch conditions, tested on the flags of the branch's own alu op.
  typedef enum logic [1:0] {
    BR_EQ     = 2'd0, // zero set.
    BR_NE     = 2'd1, // zero clear.
    BR_LT     = 2'd2, // negative set.
    BR_ALWAYS = 2'd3
  } branch_cond_e;

endpackage

/* hdl/cpu16_pipe_pkg.sv */
package cpu16_pipe_pkg;

  // source of the register file write data at writeback.
  typedef enum logic [1:0] {
    WB_ALU  = 2'd0,
    WB_MEM  = 2'd1,
    WB_LINK = 2'd2 // pc_added, for jal.
  } wb_src_e;

endpackage

/* hdl/ex_mem_reg.sv */
`include "cpu16_defines.svh"

module ex_mem_reg (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        squash,
  input  logic [`CPU16_DW-1:0]        aluout,
  input  logic [`CPU16_FW-1:0]        flag,
  input  logic [`CPU16_DW-1:0]        rdata2,
  input  logic [`CPU16_DW-1:0]        branch_target,
  input  logic [`CPU16_DW-1:0]        pc_added,
  input  logic [`CPU16_RW-1:0]        rf_waddr,
  input  logic                        rf_wen,
  input  logic                        dmem_wen,
  input  logic                        mem2reg,
  input  logic                        branch,
  input  cpu16_isa_pkg::branch_cond_e branch_cond,
  input  logic                        jal,
  output logic [`CPU16_DW-1:0]        aluout_exmem,
  output logic [`CPU16_FW-1:0]        flag_exmem,
  output logic [`CPU16_DW-1:0]        rdata2_exmem,
  output logic [`CPU16_DW-1:0]        branch_target_exmem,
  output logic [`CPU16_DW-1:0]        pc_added_exmem,
  output logic [`CPU16_RW-1:0]        rf_waddr_exmem,
  output logic                        rf_wen_exmem,
  output logic                        dmem_wen_exmem,
  output logic                        mem2reg_exmem,
  output logic                        branch_exmem,
  output cpu16_isa_pkg::branch_cond_e branch_cond_exmem,
  output logic                        jal_exmem
);

  // control bits. a taken branch in mem kills the op now in execute.
  always_ff @(posedge clk)
  begin
    if (reset || squash)
    begin
      rf_wen_exmem   <= 1'b0;
      dmem_wen_exmem <= 1'b0;
      branch_exmem   <= 1'b0;
      jal_exmem      <= 1'b0;
    end
    else
    begin
      rf_wen_exmem   <= rf_wen;
      dmem_wen_exmem <= dmem_wen;
      branch_exmem   <= branch;
      jal_exmem      <= jal;
    end
  end

  // payload, loaded every cycle.
  always_ff @(posedge clk)
  begin
    aluout_exmem        <= aluout;
    flag_exmem          <= flag;
    rdata2_exmem        <= rdata2; // store data.
    branch_target_exmem <= branch_target;
    pc_added_exmem      <= pc_added;
    rf_waddr_exmem      <= rf_waddr;
    mem2reg_exmem       <= mem2reg;
    branch_cond_exmem   <= branch_cond;
  end

endmodule

/* hdl/exec_alu.sv */
`include "cpu16_defines.svh"

module exec_alu (
  input  cpu16_isa_pkg::alu_op_e alu_op,
  input  logic [`CPU16_DW-1:0]   rdata1,
  input  logic [`CPU16_DW-1:0]   rdata2,
  input  logic [`CPU16_DW-1:0]   extended,
  input  logic [`CPU16_DW-1:0]   pc_added,
  input  logic                   use_imm,
  output logic [`CPU16_DW-1:0]   aluout,
  output logic [`CPU16_FW-1:0]   flag,
  output logic [`CPU16_DW-1:0]   branch_target
);

  logic [`CPU16_DW-1:0] op_b;
  logic [`CPU16_DW:0]   sum_add;
  logic [`CPU16_DW:0]   sum_sub;
  logic [`CPU16_DW-1:0] result;
  logic                 carry;

  assign op_b = use_imm ? extended : rdata2;

  // sub is a + ~b + 1, so the top bit is the no-borrow.
  assign sum_add = {1'b0, rdata1} + {1'b0, op_b};
  assign sum_sub = {1'b0, rdata1} + {1'b0, ~op_b} + {{`CPU16_DW{1'b0}}, 1'b1};

  // ==========================================================================
  // result and carry.
  // ==========================================================================
  always_comb
  begin
    carry = 1'b0;
    case (alu_op)
      cpu16_isa_pkg::ALU_ADD:
      begin
        result = sum_add[`CPU16_DW-1:0];
        carry  = sum_add[`CPU16_DW];
      end
      cpu16_isa_pkg::ALU_SUB:
      begin
        result = sum_sub[`CPU16_DW-1:0];
        carry  = sum_sub[`CPU16_DW];
      end
      cpu16_isa_pkg::ALU_AND:   result = rdata1 & op_b;
      cpu16_isa_pkg::ALU_OR:    result = rdata1 | op_b;
      cpu16_isa_pkg::ALU_XOR:   result = rdata1 ^ op_b;
      cpu16_isa_pkg::ALU_SHL:   result = {rdata1[`CPU16_DW-2:0], 1'b0};
      cpu16_isa_pkg::ALU_SHR:   result = {1'b0, rdata1[`CPU16_DW-1:1]};
      cpu16_isa_pkg::ALU_PASSB: result = op_b;
      default:                  result = op_b;
    endcase
  end

  assign aluout = result;

  assign flag[`CPU16_FLAG_Z] = (result == '0);
  assign flag[`CPU16_FLAG_C] = carry;
  assign flag[`CPU16_FLAG_N] = result[`CPU16_DW-1];

  // branch and jal share the same target adder.
  assign branch_target = pc_added + extended;

endmodule

/* hdl/mem_stage.sv */
`include "cpu16_defines.svh"

module mem_stage (
  input  logic                        clk,
  input  logic [`CPU16_DW-1:0]        aluout_exmem,
  input  logic [`CPU16_DW-1:0]        rdata2_exmem,
  input  logic [`CPU16_DW-1:0]        branch_target_exmem,
  input  logic [`CPU16_FW-1:0]        flag_exmem,
  input  logic                        dmem_wen_exmem,
  input  logic                        branch_exmem,
  input  logic                        jal_exmem,
  input  cpu16_isa_pkg::branch_cond_e branch_cond_exmem,
  output logic [`CPU16_DW-1:0]        mem_rdata,
  output logic                        branch_taken,
  output logic [`CPU16_DW-1:0]        redirect_target
);

  localparam int AW = $clog2(`CPU16_DMEM_WORDS);

  logic [`CPU16_DW-1:0] dmem [`CPU16_DMEM_WORDS];
  logic [AW-1:0]        addr;
  logic                 cond_ok;

  assign addr = aluout_exmem[AW-1:0]; // upper address bits ignored.

  // ==========================================================================
  // data memory.
  // ==========================================================================
  always_ff @(posedge clk)
  begin
    if (dmem_wen_exmem)
    begin
      dmem[addr] <= rdata2_exmem;
    end
  end

  assign mem_rdata = dmem[addr]; // read is combinational.

  // ==========================================================================
  // branch resolution.
  // ==========================================================================
  always_comb
  begin
    case (branch_cond_exmem)
      cpu16_isa_pkg::BR_EQ: cond_ok = flag_exmem[`CPU16_FLAG_Z];
      cpu16_isa_pkg::BR_NE: cond_ok = !flag_exmem[`CPU16_FLAG_Z];
      cpu16_isa_pkg::BR_LT: cond_ok = flag_exmem[`CPU16_FLAG_N];
      default:              cond_ok = 1'b1;
    endcase
  end

  assign branch_taken    = (branch_exmem && cond_ok) || jal_exmem;
  assign redirect_target = branch_target_exmem;

endmodule

/* hdl/mem_wb_reg.sv */
`include "cpu16_defines.svh"

module mem_wb_reg (
  input  logic                 clk,
  input  logic                 reset,
  input  logic [`CPU16_DW-1:0] aluout_exmem,
  input  logic [`CPU16_DW-1:0] mem_rdata,
  input  logic [`CPU16_DW-1:0] pc_added_exmem,
  input  logic [`CPU16_RW-1:0] rf_waddr_exmem,
  input  logic                 rf_wen_exmem,
  input  logic                 mem2reg_exmem,
  input  logic                 jal_exmem,
  output logic                 rf_wen_wb,
  output logic [`CPU16_RW-1:0] rf_waddr_wb,
  output logic [`CPU16_DW-1:0] wb_data
);

  cpu16_pipe_pkg::wb_src_e wb_src;
  logic [`CPU16_DW-1:0]    aluout_wb;
  logic [`CPU16_DW-1:0]    rdata_wb;
  logic [`CPU16_DW-1:0]    link_wb;

  always_ff @(posedge clk)
  begin
    if (reset)
      rf_wen_wb <= 1'b0;
    else
      rf_wen_wb <= rf_wen_exmem;
  end

  always_ff @(posedge clk)
  begin
    rf_waddr_wb <= rf_waddr_exmem;
    aluout_wb   <= aluout_exmem;
    rdata_wb    <= mem_rdata;
    link_wb     <= pc_added_exmem;
    if (jal_exmem)
      wb_src <= cpu16_pipe_pkg::WB_LINK; // link wins over a load.
    else if (mem2reg_exmem)
      wb_src <= cpu16_pipe_pkg::WB_MEM;
    else
      wb_src <= cpu16_pipe_pkg::WB_ALU;
  end

  always_comb
  begin
    case (wb_src)
      cpu16_pipe_pkg::WB_MEM:  wb_data = rdata_wb;
      cpu16_pipe_pkg::WB_LINK: wb_data = link_wb;
      default:                 wb_data = aluout_wb;
    endcase
  end

endmodule

/* tb/backend_vectors.txt */
// op r1 r2 ext imm pc waddr wen dwen m2r br cond jal | tk target wen_wb waddr_wb wb_data
// ops 0 add 1 sub 2 and 3 or 4 xor 5 shl 6 shr 7 passb, conds 0 eq 1 ne 2 lt 3 always
0 1234 1111 0000 0 0010 1 1 0 0 0 0 0 0 0000 1 1 2345
0 fff0 0000 0020 1 0012 2 1 0 0 0 0 0 0 0000 1 2 0010
1 5000 1234 0000 0 0014 3 1 0 0 0 0 0 0 0000 1 3 3dcc
2 f0f0 0000 3c3c 1 0016 4 1 0 0 0 0 0 0 0000 1 4 3030
3 f0f0 0f00 0000 0 0018 5 1 0 0 0 0 0 0 0000 1 5 fff0
4 aaaa 0000 ffff 1 001a 6 1 0 0 0 0 0 0 0000 1 6 5555
5 8001 0000 0000 0 001c 7 1 0 0 0 0 0 0 0000 1 7 0002
6 8001 0000 0000 0 001e 8 1 0 0 0 0 0 0 0000 1 8 4000
7 0000 0000 beef 1 0020 9 1 0 0 0 0 0 0 0000 1 9 beef
0 0040 cafe 0003 1 0022 0 0 1 0 0 0 0 0 0000 0 0 0000
0 0040 0000 0003 1 0024 a 1 0 1 0 0 0 0 0000 1 a cafe
1 0005 0003 0010 0 0020 0 0 0 0 1 0 0 0 0000 0 0 0000
0 0001 0001 0000 0 0022 b 1 0 0 0 0 0 0 0000 1 b 0002
1 0007 0007 fff0 0 0030 0 0 0 0 1 0 0 1 0020 0 0 0000
0 0001 0001 0000 0 0032 c 1 0 0 0 0 0 0 0000 0 0 0000
1 0003 0005 0100 0 0040 0 0 0 0 1 2 0 1 0140 0 0 0000
0 0040 dead 0003 1 0042 0 0 1 0 0 0 0 0 0000 0 0 0000
0 0040 0000 0003 1 0044 d 1 0 1 0 0 0 0 0000 1 d cafe
4 00ff 000f 0004 0 0050 0 0 0 0 1 1 0 1 0054 0 0 0000
0 0000 0000 0001 0 0099 e 1 0 0 0 0 1 0 0000 0 0 0000
0 0000 0000 0020 0 0060 f 1 0 0 0 0 1 1 0080 1 f 0060
0 1111 1111 0000 0 0062 1 1 0 0 0 0 0 0 0000 0 0 0000
1 0005 0003 0000 0 0070 0 0 0 0 1 2 0 0 0000 0 0 0000
1 0004 0004 0008 0 0072 0 0 0 0 1 1 0 0 0000 0 0 0000
0 0100 0000 0001 1 0074 2 1 0 0 0 0 0 0 0000 1 2 0101

/* tb/tb_backend.sv */
`include "cpu16_defines.svh"

module tb_backend;
  timeunit 1ns;
  timeprecision 100ps;

  localparam string VEC_FILE = "tb/backend_vectors.txt";
  localparam int    NF       = 18; // fields per vector line.
  localparam int    MAXV     = 64;

  // field positions within a vector line.
  localparam int F_OP     = 0;
  localparam int F_R1     = 1;
  localparam int F_R2     = 2;
  localparam int F_EXT    = 3;
  localparam int F_IMM    = 4;
  localparam int F_PC     = 5;
  localparam int F_WADDR  = 6;
  localparam int F_WEN    = 7;
  localparam int F_DWEN   = 8;
  localparam int F_M2R    = 9;
  localparam int F_BR     = 10;
  localparam int F_COND   = 11;
  localparam int F_JAL    = 12;
  localparam int F_TK     = 13; // expected redirect, one cycle later.
  localparam int F_TGT    = 14;
  localparam int F_WWEN   = 15; // expected writeback, two cycles later.
  localparam int F_WWADDR = 16;
  localparam int F_WDATA  = 17;

  logic                        clk;
  logic                        reset;
  cpu16_isa_pkg::alu_op_e      alu_op;
  logic [`CPU16_DW-1:0]        rdata1;
  logic [`CPU16_DW-1:0]        rdata2;
  logic [`CPU16_DW-1:0]        extended;
  logic                        use_imm;
  logic [`CPU16_DW-1:0]        pc_added;
  logic [`CPU16_RW-1:0]        rf_waddr;
  logic                        rf_wen;
  logic                        dmem_wen;
  logic                        mem2reg;
  logic                        branch;
  cpu16_isa_pkg::branch_cond_e branch_cond;
  logic                        jal;
  logic                        rf_wen_wb;
  logic [`CPU16_RW-1:0]        rf_waddr_wb;
  logic [`CPU16_DW-1:0]        wb_data;
  logic                        branch_taken;
  logic [`CPU16_DW-1:0]        redirect_target;

  logic [15:0] vec [MAXV][NF];
  int          vec_errs [MAXV];
  int          nvec = 0;
  int          pass_cnt = 0;
  int          fail_cnt = 0;

  cpu16_backend dut (
    .clk             (clk),
    .reset           (reset),
    .alu_op          (alu_op),
    .rdata1          (rdata1),
    .rdata2          (rdata2),
    .extended        (extended),
    .use_imm         (use_imm),
    .pc_added        (pc_added),
    .rf_waddr        (rf_waddr),
    .rf_wen          (rf_wen),
    .dmem_wen        (dmem_wen),
    .mem2reg         (mem2reg),
    .branch          (branch),
    .branch_cond     (branch_cond),
    .jal             (jal),
    .rf_wen_wb       (rf_wen_wb),
    .rf_waddr_wb     (rf_waddr_wb),
    .wb_data         (wb_data),
    .branch_taken    (branch_taken),
    .redirect_target (redirect_target)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ==========================================================================
  // vector file and stimulus.
  // ==========================================================================
  task automatic load_vectors();
    int          fd;
    int          cnt;
    int          n;
    string       line;
    logic [15:0] f [NF];
    cnt = 0;
    fd = $fopen(VEC_FILE, "r");
    if (fd == 0)
    begin
      $display("could not open %s", VEC_FILE);
    end
    else
    begin
      while ($fgets(line, fd) != 0 && cnt < MAXV)
      begin
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                    f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17]);
        if (n == NF) // comment lines do not parse.
        begin
          for (int j = 0; j < NF; j++)
            vec[cnt][j] = f[j];
          vec_errs[cnt] = 0;
          cnt++;
        end
      end
      $fclose(fd);
    end
    nvec = cnt;
  endtask

  task automatic drive_vector(input int i);
    alu_op      = cpu16_isa_pkg::alu_op_e'(vec[i][F_OP][2:0]);
    rdata1      = vec[i][F_R1];
    rdata2      = vec[i][F_R2];
    extended    = vec[i][F_EXT];
    use_imm     = vec[i][F_IMM][0];
    pc_added    = vec[i][F_PC];
    rf_waddr    = vec[i][F_WADDR][`CPU16_RW-1:0];
    rf_wen      = vec[i][F_WEN][0];
    dmem_wen    = vec[i][F_DWEN][0];
    mem2reg     = vec[i][F_M2R][0];
    branch      = vec[i][F_BR][0];
    branch_cond = cpu16_isa_pkg::branch_cond_e'(vec[i][F_COND][1:0]);
    jal         = vec[i][F_JAL][0];
  endtask

  task automatic drive_idle();
    alu_op      = cpu16_isa_pkg::ALU_ADD;
    rdata1      = '0;
    rdata2      = '0;
    extended    = '0;
    use_imm     = 1'b0;
    pc_added    = '0;
    rf_waddr    = '0;
    rf_wen      = 1'b0;
    dmem_wen    = 1'b0;
    mem2reg     = 1'b0;
    branch      = 1'b0;
    branch_cond = cpu16_isa_pkg::BR_EQ;
    jal         = 1'b0;
  endtask

  // ==========================================================================
  // checks.
  // ==========================================================================
  task automatic check_redirect(input int i);
    if (branch_taken !== vec[i][F_TK][0])
    begin
      $display("Error at %0t ns: vector %0d branch_taken %b, expected %b",
               $time, i, branch_taken, vec[i][F_TK][0]);
      vec_errs[i]++;
    end
    else if (vec[i][F_TK][0] && redirect_target !== vec[i][F_TGT])
    begin
      $display("Error at %0t ns: vector %0d redirect_target %h, expected %h",
               $time, i, redirect_target, vec[i][F_TGT]);
      vec_errs[i]++;
    end
  endtask

  task automatic check_writeback(input int i);
    if (rf_wen_wb !== vec[i][F_WWEN][0])
    begin
      $display("Error at %0t ns: vector %0d rf_wen_wb %b, expected %b",
               $time, i, rf_wen_wb, vec[i][F_WWEN][0]);
      vec_errs[i]++;
    end
    else if (vec[i][F_WWEN][0])
    begin
      if (rf_waddr_wb !== vec[i][F_WWADDR][`CPU16_RW-1:0])
      begin
        $display("Error at %0t ns: vector %0d rf_waddr_wb %h, expected %h",
                 $time, i, rf_waddr_wb, vec[i][F_WWADDR][`CPU16_RW-1:0]);
        vec_errs[i]++;
      end
      if (wb_data !== vec[i][F_WDATA])
      begin
        $display("Error at %0t ns: vector %0d wb_data %h, expected %h",
                 $time, i, wb_data, vec[i][F_WDATA]);
        vec_errs[i]++;
      end
    end
  endtask

  task automatic report_vector(input int i);
    if (vec_errs[i] == 0)
    begin
      pass_cnt++;
      $display("vector %0d: pass", i);
    end
    else
    begin
      fail_cnt++;
      $display("vector %0d: fail, %0d errors", i, vec_errs[i]);
    end
  endtask

  // ==========================================================================
  // main sequence.
  // ==========================================================================
  initial
  begin
    $timeformat(-9, 0, "", 0);
    reset = 1'b1;
    drive_idle();
    load_vectors();
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    if (rf_wen_wb !== 1'b0 || branch_taken !== 1'b0)
    begin
      $display("Error at %0t ns: rf_wen_wb %b branch_taken %b after reset, expected 0",
               $time, rf_wen_wb, branch_taken);
      fail_cnt++;
      $display("reset: fail");
    end
    else
    begin
      pass_cnt++;
      $display("reset: pass");
    end

    if (nvec == 0)
    begin
      $display("no vectors were read from %s", VEC_FILE);
      fail_cnt++;
    end
    else
    begin
      // redirect shows one cycle after the inputs, writeback two cycles after.
      for (int k = 0; k < nvec + 2; k++)
      begin
        if (k >= 1 && k - 1 < nvec)
          check_redirect(k - 1);
        if (k >= 2)
        begin
          check_writeback(k - 2);
          report_vector(k - 2);
        end
        if (k < nvec)
          drive_vector(k);
        else
          drive_idle();
        @(negedge clk);
      end
    end

    $display("tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

  // watchdog, sized from the vector count.
  initial
  begin
    wait (nvec > 0);
    #(nvec * 20 + 200);
    $display("the run timed out after %0t ns without finishing", $time);
    $display("Test FAILED");
    $finish;
  end

endmodule

/* verilog.f */
+incdir+hdl
hdl/cpu16_isa_pkg.sv
hdl/cpu16_pipe_pkg.sv
hdl/exec_alu.sv
hdl/ex_mem_reg.sv
hdl/mem_stage.sv
hdl/mem_wb_reg.sv
hdl/cpu16_backend.sv
tb/tb_backend.sv
